// ==== hdl/ctrl_map_pkg.sv ====
// Platform controller address map
// Bus widths, submodule select field and the submodule select codes

package ctrl_map_pkg;

	// **************************************************
	// APB bus widths
	// **************************************************

	localparam int APB_AW = 32;
	localparam int APB_DW = 32;

	// **************************************************
	// Submodule select field
	// **************************************************

	// Each submodule owns a 4 KiB window above this bit
	localparam int SEL_LSB = 12;
	localparam int SEL_W = 2;
	localparam int NUM_SEL = 1 << SEL_W;

	// Word offset inside a window, address bits 11 to 2
	localparam int WORD_LSB = 2;
	localparam int OFS_W = SEL_LSB - WORD_LSB;

	typedef enum logic [SEL_W-1:0]
	{
		SEL_RESET = 2'd0,
		SEL_PLATFORM = 2'd1,
		SEL_INFO = 2'd2,
		SEL_EXTERNAL = 2'd3
	} sel_e;

endpackage

// ==== hdl/ctrl_reg_pkg.sv ====
// Platform controller register definitions
// Word offsets per submodule, sequencer states and identification constants

package ctrl_reg_pkg;

	// **************************************************
	// Register word offsets
	// **************************************************

	typedef enum logic [ctrl_map_pkg::OFS_W-1:0]
	{
		RST_STATUS = 10'd0,
		RST_REQUEST = 10'd1
	} rst_reg_e;

	// Core k program counter at PLAT_PC_BASE + k
	typedef enum logic [ctrl_map_pkg::OFS_W-1:0]
	{
		PLAT_BOOT_MODE = 10'd0,
		PLAT_INITIALIZED = 10'd1,
		PLAT_APP_FINISHED = 10'd2,
		PLAT_SCRATCH = 10'd3,
		PLAT_PC_BASE = 10'd16
	} plat_reg_e;

	typedef enum logic [ctrl_map_pkg::OFS_W-1:0]
	{
		INFO_VERSION = 10'd0,
		INFO_DATE = 10'd1,
		INFO_NUM_CORE = 10'd2,
		INFO_NUM_RESET = 10'd3
	} info_reg_e;

	// **************************************************
	// Constants and states
	// **************************************************

	localparam logic [ctrl_map_pkg::APB_DW-1:0] DESIGN_VERSION = 32'h0001_0400;
	localparam logic [ctrl_map_pkg::APB_DW-1:0] DESIGN_DATE = 32'h1A2B_3C4D;
	localparam int BW_BOOT_MODE = 2;

	typedef enum logic [1:0] {SEQ_HOLD, SEQ_STEP, SEQ_DONE} seq_state_e;

endpackage

// ==== hdl/apb_splitter.sv ====
// APB splitter
// Decodes the submodule select bits and routes one transfer to one of
// four slave ports, returning the selected slave's response

module apb_splitter
(
	input  logic clk,
	input  logic i_rst_n,

	input  logic i_psel,
	input  logic i_penable,
	input  logic [ctrl_map_pkg::APB_AW-1:0] i_paddr,
	input  logic i_pwrite,
	input  logic [ctrl_map_pkg::APB_DW-1:0] i_pwdata,
	output logic [ctrl_map_pkg::APB_DW-1:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,

	output logic [ctrl_map_pkg::NUM_SEL-1:0] o_s_psel,
	output logic [ctrl_map_pkg::NUM_SEL-1:0] o_s_penable,
	output logic [ctrl_map_pkg::APB_AW-1:0] o_s_paddr,
	output logic o_s_pwrite,
	output logic [ctrl_map_pkg::APB_DW-1:0] o_s_pwdata,
	input  logic [ctrl_map_pkg::APB_DW-1:0] i_s_prdata [ctrl_map_pkg::NUM_SEL],
	input  logic [ctrl_map_pkg::NUM_SEL-1:0] i_s_pready,
	input  logic [ctrl_map_pkg::NUM_SEL-1:0] i_s_pslverr
);

	ctrl_map_pkg::sel_e sel;
	logic [ctrl_map_pkg::NUM_SEL-1:0] hit;

	// **************************************************
	// Address decode
	// **************************************************

	assign sel = ctrl_map_pkg::sel_e'(i_paddr[ctrl_map_pkg::SEL_LSB +: ctrl_map_pkg::SEL_W]);

	always_comb
	begin
		for (int k = 0; k < ctrl_map_pkg::NUM_SEL; k++)
		begin
			hit[k] = (sel == ctrl_map_pkg::sel_e'(k));
		end
	end

	// Only the selected slave sees psel, in both phases
	assign o_s_psel = hit & {ctrl_map_pkg::NUM_SEL{i_psel}};
	assign o_s_penable = hit & {ctrl_map_pkg::NUM_SEL{i_psel & i_penable}};

	// Full address goes down, slaves use the word offset only
	assign o_s_paddr = i_paddr;
	assign o_s_pwrite = i_pwrite;
	assign o_s_pwdata = i_pwdata;

	// **************************************************
	// Response return
	// **************************************************

	assign o_prdata = i_s_prdata[sel];
	assign o_pready = i_s_pready[sel];
	assign o_pslverr = i_s_pslverr[sel];

endmodule

// ==== hdl/reset_sequencer.sv ====
// Reset sequencer
// Releases the reset domains one by one, STEP_CYCLES apart, and lets
// software re-assert any set of them through the request register

module reset_sequencer
#(
	parameter int NUM_RESET = 3,
	parameter int STEP_CYCLES = 4
)
(
	input  logic clk,
	input  logic i_rst_n,

	input  logic i_psel,
	input  logic i_penable,
	input  logic [ctrl_map_pkg::APB_AW-1:0] i_paddr,
	input  logic i_pwrite,
	input  logic [ctrl_map_pkg::APB_DW-1:0] i_pwdata,
	output logic [ctrl_map_pkg::APB_DW-1:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,

	output logic [NUM_RESET-1:0] o_rst_n_seq
);

	localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
	localparam int IDX_W = (NUM_RESET > 1) ? $clog2(NUM_RESET) : 1;
	localparam logic [CNT_W-1:0] STEP_LAST = CNT_W'(STEP_CYCLES - 1);

	ctrl_reg_pkg::seq_state_e state;
	logic [CNT_W-1:0] step_cnt;
	logic [IDX_W-1:0] rel_idx;
	logic [NUM_RESET-1:0] rst_n_seq;
	logic [ctrl_map_pkg::OFS_W-1:0] ofs;
	logic req_wr;
	logic err;

	// **************************************************
	// Register access
	// **************************************************

	assign ofs = i_paddr[ctrl_map_pkg::SEL_LSB-1:ctrl_map_pkg::WORD_LSB];
	assign req_wr = i_psel && i_penable && i_pwrite && (ofs == ctrl_reg_pkg::RST_REQUEST);

	always_comb
	begin
		o_prdata = '0;
		err = 1'b0;
		case (ofs)
			ctrl_reg_pkg::RST_STATUS:
			begin
				o_prdata = ctrl_map_pkg::APB_DW'(rst_n_seq);
				err = i_pwrite;
			end
			// Request register is write only
			ctrl_reg_pkg::RST_REQUEST: err = !i_pwrite;
			default: err = 1'b1;
		endcase
	end

	assign o_pready = 1'b1;
	assign o_pslverr = i_psel && err;

	// **************************************************
	// Release sequence
	// **************************************************

	// Lowest domain still held in reset
	always_comb
	begin
		rel_idx = '0;
		for (int i = NUM_RESET - 1; i >= 0; i--)
		begin
			if (!rst_n_seq[i])
				rel_idx = IDX_W'(i);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
		begin
			state <= ctrl_reg_pkg::SEQ_HOLD;
			step_cnt <= '0;
			rst_n_seq <= '0;
		end
		else if (req_wr)
		begin
			// A new request restarts the count
			state <= ctrl_reg_pkg::SEQ_STEP;
			step_cnt <= '0;
			rst_n_seq <= rst_n_seq & ~i_pwdata[NUM_RESET-1:0];
		end
		else
		begin
			case (state)
				ctrl_reg_pkg::SEQ_HOLD:
				begin
					state <= ctrl_reg_pkg::SEQ_STEP;
					step_cnt <= '0;
				end
				ctrl_reg_pkg::SEQ_STEP:
				begin
					if (&rst_n_seq)
						state <= ctrl_reg_pkg::SEQ_DONE;
					else if (step_cnt == STEP_LAST)
					begin
						rst_n_seq[rel_idx] <= 1'b1;
						step_cnt <= '0;
					end
					else
						step_cnt <= step_cnt + 1'b1;
				end
				default: state <= ctrl_reg_pkg::SEQ_DONE;
			endcase
		end
	end

	assign o_rst_n_seq = rst_n_seq;

endmodule

// ==== hdl/platform_regs.sv ====
// Platform register block
// Reports boot mode, init flags and core program counters, and holds
// the scratch and application-finished registers

module platform_regs
#(
	parameter int NUM_CORE = 2
)
(
	input  logic clk,
	input  logic i_rst_n,

	input  logic i_psel,
	input  logic i_penable,
	input  logic [ctrl_map_pkg::APB_AW-1:0] i_paddr,
	input  logic i_pwrite,
	input  logic [ctrl_map_pkg::APB_DW-1:0] i_pwdata,
	output logic [ctrl_map_pkg::APB_DW-1:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,

	input  logic [ctrl_reg_pkg::BW_BOOT_MODE-1:0] i_boot_mode,
	input  logic [NUM_CORE-1:0] i_initialized,
	input  logic [NUM_CORE*ctrl_map_pkg::APB_DW-1:0] i_pc_list,
	output logic o_app_finished
);

	localparam int DW = ctrl_map_pkg::APB_DW;
	localparam int OW = ctrl_map_pkg::OFS_W;

	logic [OW-1:0] ofs;
	logic [DW-1:0] scratch;
	logic app_finished;
	logic wr;
	logic mapped;
	logic read_only;

	assign ofs = i_paddr[ctrl_map_pkg::SEL_LSB-1:ctrl_map_pkg::WORD_LSB];
	assign wr = i_psel && i_penable && i_pwrite;

	// **************************************************
	// Read decode
	// **************************************************

	always_comb
	begin
		o_prdata = '0;
		mapped = 1'b1;
		read_only = 1'b1;
		case (ofs)
			ctrl_reg_pkg::PLAT_BOOT_MODE: o_prdata = DW'(i_boot_mode);
			ctrl_reg_pkg::PLAT_INITIALIZED: o_prdata = DW'(i_initialized);
			ctrl_reg_pkg::PLAT_APP_FINISHED:
			begin
				o_prdata = DW'(app_finished);
				read_only = 1'b0;
			end
			ctrl_reg_pkg::PLAT_SCRATCH:
			begin
				o_prdata = scratch;
				read_only = 1'b0;
			end
			default:
			begin
				mapped = 1'b0;
				for (int k = 0; k < NUM_CORE; k++)
				begin
					if (ofs == OW'(ctrl_reg_pkg::PLAT_PC_BASE + k))
					begin
						o_prdata = i_pc_list[k*DW +: DW];
						mapped = 1'b1;
					end
				end
			end
		endcase
	end

	assign o_pready = 1'b1;
	assign o_pslverr = i_psel && (!mapped || (i_pwrite && read_only));

	// **************************************************
	// Writable registers
	// **************************************************

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
		begin
			scratch <= '0;
			app_finished <= 1'b0;
		end
		else if (wr)
		begin
			if (ofs == ctrl_reg_pkg::PLAT_SCRATCH)
				scratch <= i_pwdata;
			if (ofs == ctrl_reg_pkg::PLAT_APP_FINISHED)
				app_finished <= i_pwdata[0];
		end
	end

	assign o_app_finished = app_finished;

endmodule

// ==== hdl/design_info_rom.sv ====
// Design information block
// Read-only version, date and configuration counts

module design_info_rom
#(
	parameter int NUM_CORE = 2,
	parameter int NUM_RESET = 3
)
(
	input  logic clk,
	input  logic i_rst_n,

	input  logic i_psel,
	input  logic i_penable,
	input  logic [ctrl_map_pkg::APB_AW-1:0] i_paddr,
	input  logic i_pwrite,
	input  logic [ctrl_map_pkg::APB_DW-1:0] i_pwdata,
	output logic [ctrl_map_pkg::APB_DW-1:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr
);

	localparam int DW = ctrl_map_pkg::APB_DW;

	logic [ctrl_map_pkg::OFS_W-1:0] ofs;
	logic [DW-1:0] rom_data;
	logic rom_hit;
	logic [DW-1:0] rdata_q;
	logic err_q;
	logic setup;

	assign ofs = i_paddr[ctrl_map_pkg::SEL_LSB-1:ctrl_map_pkg::WORD_LSB];
	assign setup = i_psel && !i_penable;

	always_comb
	begin
		rom_data = '0;
		rom_hit = 1'b1;
		case (ofs)
			ctrl_reg_pkg::INFO_VERSION: rom_data = ctrl_reg_pkg::DESIGN_VERSION;
			ctrl_reg_pkg::INFO_DATE: rom_data = ctrl_reg_pkg::DESIGN_DATE;
			ctrl_reg_pkg::INFO_NUM_CORE: rom_data = DW'(NUM_CORE);
			ctrl_reg_pkg::INFO_NUM_RESET: rom_data = DW'(NUM_RESET);
			default: rom_hit = 1'b0;
		endcase
	end

	// Response is captured in the setup cycle, ready for the access cycle
	always_ff @(posedge clk)
	begin
		if (setup)
			rdata_q <= rom_data;
	end

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
			err_q <= 1'b0;
		else if (setup)
			err_q <= i_pwrite || !rom_hit;
	end

	assign o_prdata = rdata_q;
	assign o_pready = 1'b1;
	assign o_pslverr = err_q;

endmodule

// ==== hdl/platform_controller.sv ====
// Platform controller top
// APB splitter feeding the reset sequencer, platform registers, design
// information block and the external debug window

module platform_controller
#(
	parameter int NUM_CORE = 2,
	parameter int NUM_RESET = 3,
	parameter int STEP_CYCLES = 4
)
(
	input  logic clk,
	input  logic i_rst_n,

	input  logic i_psel,
	input  logic i_penable,
	input  logic [ctrl_map_pkg::APB_AW-1:0] i_paddr,
	input  logic i_pwrite,
	input  logic [ctrl_map_pkg::APB_DW-1:0] i_pwdata,
	output logic [ctrl_map_pkg::APB_DW-1:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,

	input  logic [ctrl_reg_pkg::BW_BOOT_MODE-1:0] i_boot_mode,
	input  logic [NUM_CORE-1:0] i_initialized,
	input  logic [NUM_CORE*ctrl_map_pkg::APB_DW-1:0] i_pc_list,
	output logic o_app_finished,
	output logic [NUM_RESET-1:0] o_rst_n_seq,

	output logic o_ext_psel,
	output logic o_ext_penable,
	output logic [ctrl_map_pkg::APB_AW-1:0] o_ext_paddr,
	output logic o_ext_pwrite,
	output logic [ctrl_map_pkg::APB_DW-1:0] o_ext_pwdata,
	input  logic [ctrl_map_pkg::APB_DW-1:0] i_ext_prdata,
	input  logic i_ext_pready,
	input  logic i_ext_pslverr
);

	logic [ctrl_map_pkg::NUM_SEL-1:0] s_psel;
	logic [ctrl_map_pkg::NUM_SEL-1:0] s_penable;
	logic [ctrl_map_pkg::APB_AW-1:0] s_paddr;
	logic s_pwrite;
	logic [ctrl_map_pkg::APB_DW-1:0] s_pwdata;
	logic [ctrl_map_pkg::APB_DW-1:0] s_prdata [ctrl_map_pkg::NUM_SEL];
	logic [ctrl_map_pkg::NUM_SEL-1:0] s_pready;
	logic [ctrl_map_pkg::NUM_SEL-1:0] s_pslverr;

	// **************************************************
	// Bus split
	// **************************************************

	apb_splitter apb_splitter_i
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_paddr(i_paddr),
		.i_pwrite(i_pwrite),
		.i_pwdata(i_pwdata),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr),
		.o_s_psel(s_psel),
		.o_s_penable(s_penable),
		.o_s_paddr(s_paddr),
		.o_s_pwrite(s_pwrite),
		.o_s_pwdata(s_pwdata),
		.i_s_prdata(s_prdata),
		.i_s_pready(s_pready),
		.i_s_pslverr(s_pslverr)
	);

	// **************************************************
	// Submodules
	// **************************************************

	reset_sequencer
	#(
		.NUM_RESET(NUM_RESET),
		.STEP_CYCLES(STEP_CYCLES)
	)
	reset_sequencer_i
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_psel(s_psel[ctrl_map_pkg::SEL_RESET]),
		.i_penable(s_penable[ctrl_map_pkg::SEL_RESET]),
		.i_paddr(s_paddr),
		.i_pwrite(s_pwrite),
		.i_pwdata(s_pwdata),
		.o_prdata(s_prdata[ctrl_map_pkg::SEL_RESET]),
		.o_pready(s_pready[ctrl_map_pkg::SEL_RESET]),
		.o_pslverr(s_pslverr[ctrl_map_pkg::SEL_RESET]),
		.o_rst_n_seq(o_rst_n_seq)
	);

	platform_regs
	#(
		.NUM_CORE(NUM_CORE)
	)
	platform_regs_i
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_psel(s_psel[ctrl_map_pkg::SEL_PLATFORM]),
		.i_penable(s_penable[ctrl_map_pkg::SEL_PLATFORM]),
		.i_paddr(s_paddr),
		.i_pwrite(s_pwrite),
		.i_pwdata(s_pwdata),
		.o_prdata(s_prdata[ctrl_map_pkg::SEL_PLATFORM]),
		.o_pready(s_pready[ctrl_map_pkg::SEL_PLATFORM]),
		.o_pslverr(s_pslverr[ctrl_map_pkg::SEL_PLATFORM]),
		.i_boot_mode(i_boot_mode),
		.i_initialized(i_initialized),
		.i_pc_list(i_pc_list),
		.o_app_finished(o_app_finished)
	);

	design_info_rom
	#(
		.NUM_CORE(NUM_CORE),
		.NUM_RESET(NUM_RESET)
	)
	design_info_rom_i
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_psel(s_psel[ctrl_map_pkg::SEL_INFO]),
		.i_penable(s_penable[ctrl_map_pkg::SEL_INFO]),
		.i_paddr(s_paddr),
		.i_pwrite(s_pwrite),
		.i_pwdata(s_pwdata),
		.o_prdata(s_prdata[ctrl_map_pkg::SEL_INFO]),
		.o_pready(s_pready[ctrl_map_pkg::SEL_INFO]),
		.o_pslverr(s_pslverr[ctrl_map_pkg::SEL_INFO])
	);

	// External debug window goes straight out
	assign o_ext_psel = s_psel[ctrl_map_pkg::SEL_EXTERNAL];
	assign o_ext_penable = s_penable[ctrl_map_pkg::SEL_EXTERNAL];
	assign o_ext_paddr = s_paddr;
	assign o_ext_pwrite = s_pwrite;
	assign o_ext_pwdata = s_pwdata;
	assign s_prdata[ctrl_map_pkg::SEL_EXTERNAL] = i_ext_prdata;
	assign s_pready[ctrl_map_pkg::SEL_EXTERNAL] = i_ext_pready;
	assign s_pslverr[ctrl_map_pkg::SEL_EXTERNAL] = i_ext_pslverr;

endmodule

// ==== test/tb_model.svh ====
// Testbench reference model and compare tasks
// Expected APB read data and pslverr from the address map and register mirrors

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

	// Expected response of one transfer, from the register map rules
	function automatic void expected_read(input logic [AW-1:0] addr, input logic write,
		output logic [DW-1:0] data, output logic err);
		int ofs;
		ofs = int'(addr[ctrl_map_pkg::SEL_LSB-1:ctrl_map_pkg::WORD_LSB]);
		data = '0;
		err = 1'b0;
		case (addr[ctrl_map_pkg::SEL_LSB +: ctrl_map_pkg::SEL_W])
			ctrl_map_pkg::SEL_RESET:
			begin
				if (ofs == 0)
				begin
					data = DW'(rst_m);
					err = write;
				end
				else if (ofs == 1)
					err = !write;
				else
					err = 1'b1;
			end
			ctrl_map_pkg::SEL_PLATFORM:
			begin
				if (ofs == 0)
				begin
					data = DW'(boot_mode);
					err = write;
				end
				else if (ofs == 1)
				begin
					data = DW'(initialized);
					err = write;
				end
				else if (ofs == 2)
					data = DW'(app_m);
				else if (ofs == 3)
					data = scratch_m;
				else if (ofs >= 16 && ofs < 16 + NUM_CORE)
				begin
					data = pc_list[(ofs-16)*DW +: DW];
					err = write;
				end
				else
					err = 1'b1;
			end
			ctrl_map_pkg::SEL_INFO:
			begin
				err = write || (ofs > 3);
				if (ofs == 0)
					data = ctrl_reg_pkg::DESIGN_VERSION;
				else if (ofs == 1)
					data = ctrl_reg_pkg::DESIGN_DATE;
				else if (ofs == 2)
					data = DW'(NUM_CORE);
				else if (ofs == 3)
					data = DW'(NUM_RESET);
			end
			default:
			begin
				if (ofs < 16)
					data = ext_m[ofs];
				else
					err = 1'b1;
			end
		endcase
	endfunction

	task automatic compare_data(input string name, input logic [DW-1:0] got,
		input logic [DW-1:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "data compare");
		end
	endtask

	task automatic compare_err(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "flag compare");
		end
	endtask

	task automatic compare_rst(input logic [NUM_RESET-1:0] got, input logic [NUM_RESET-1:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch o_rst_n_seq: got 0x%h, expected 0x%h", got, exp);
			$display("Simulation FAILED");
			$fatal(1, "reset vector compare");
		end
	endtask

`endif

// ==== test/tb_platform_controller.sv ====
// Platform controller testbench
// Drives the upstream APB bus, models the external slave and checks
// every submodule against a reference model

module tb_platform_controller;

	localparam int NUM_CORE = 2;
	localparam int NUM_RESET = 3;
	localparam int STEP_CYCLES = 4;
	localparam int AW = ctrl_map_pkg::APB_AW;
	localparam int DW = ctrl_map_pkg::APB_DW;
	localparam int OW = ctrl_map_pkg::OFS_W;
	localparam int CLK_PERIOD = 4;
	localparam int NUM_EXT_OPS = 32;
	localparam int NUM_REQ_ROUNDS = 3;
	localparam int NUM_XFER = 26 + NUM_EXT_OPS + 2 * NUM_REQ_ROUNDS;
	localparam int TIMEOUT_CYCLES = NUM_XFER * 200 + (NUM_RESET + 1) * STEP_CYCLES + 10;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic [AW-1:0] paddr;
	logic pwrite;
	logic [DW-1:0] pwdata;
	logic [DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [ctrl_reg_pkg::BW_BOOT_MODE-1:0] boot_mode;
	logic [NUM_CORE-1:0] initialized;
	logic [NUM_CORE*DW-1:0] pc_list;
	logic app_finished;
	logic [NUM_RESET-1:0] rst_n_seq;
	logic ext_psel;
	logic ext_penable;
	logic [AW-1:0] ext_paddr;
	logic ext_pwrite;
	logic [DW-1:0] ext_pwdata;
	logic [DW-1:0] ext_prdata;
	logic ext_pready;
	logic ext_pslverr;

	// Register mirrors and external slave memory
	logic [DW-1:0] scratch_m;
	logic app_m;
	logic [NUM_RESET-1:0] rst_m;
	logic [DW-1:0] ext_m [16];
	logic [DW-1:0] ext_mem [16];
	int wait_left;

	`include "tb_model.svh"

	platform_controller
	#(
		.NUM_CORE(NUM_CORE),
		.NUM_RESET(NUM_RESET),
		.STEP_CYCLES(STEP_CYCLES)
	)
	platform_controller_i
	(
		.clk(clk),
		.i_rst_n(rst_n),
		.i_psel(psel),
		.i_penable(penable),
		.i_paddr(paddr),
		.i_pwrite(pwrite),
		.i_pwdata(pwdata),
		.o_prdata(prdata),
		.o_pready(pready),
		.o_pslverr(pslverr),
		.i_boot_mode(boot_mode),
		.i_initialized(initialized),
		.i_pc_list(pc_list),
		.o_app_finished(app_finished),
		.o_rst_n_seq(rst_n_seq),
		.o_ext_psel(ext_psel),
		.o_ext_penable(ext_penable),
		.o_ext_paddr(ext_paddr),
		.o_ext_pwrite(ext_pwrite),
		.o_ext_pwdata(ext_pwdata),
		.i_ext_prdata(ext_prdata),
		.i_ext_pready(ext_pready),
		.i_ext_pslverr(ext_pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout, a transfer or the test never completed");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	// **************************************************
	// External APB slave with random wait states
	// **************************************************

	always @(posedge clk)
	begin : ext_slave
		int draw;
		int ofs;
		ofs = int'(ext_paddr[ctrl_map_pkg::SEL_LSB-1:ctrl_map_pkg::WORD_LSB]);
		if (ext_psel && !ext_penable)
		begin
			draw = $urandom_range(0, 3);
			wait_left <= draw;
			ext_pready <= (draw == 0);
			ext_pslverr <= (ofs >= 16);
			ext_prdata <= (ofs < 16) ? ext_mem[ofs] : '0;
		end
		else if (ext_psel && ext_penable)
		begin
			if (ext_pready)
			begin
				if (ext_pwrite && ofs < 16)
					ext_mem[ofs] <= ext_pwdata;
				ext_pready <= 1'b0;
			end
			else if (wait_left <= 1)
				ext_pready <= 1'b1;
			else
				wait_left <= wait_left - 1;
		end
	end

	// **************************************************
	// Bus access helpers
	// **************************************************

	function automatic logic [DW-1:0] fill_word(input int i);
		return 32'hC0DE_0000 | DW'(i * 32'h0000_1111);
	endfunction

	function automatic logic [AW-1:0] reg_addr(input ctrl_map_pkg::sel_e sel, input int ofs);
		logic [AW-1:0] a;
		a = '0;
		a[ctrl_map_pkg::SEL_LSB +: ctrl_map_pkg::SEL_W] = sel;
		a[ctrl_map_pkg::SEL_LSB-1:ctrl_map_pkg::WORD_LSB] = OW'(ofs);
		return a;
	endfunction

	// Returns right after the clock edge that ends the access phase
	task automatic apb_transfer(input logic [AW-1:0] addr, input logic write,
		input logic [DW-1:0] wdata, output logic [DW-1:0] rdata, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		paddr <= addr;
		pwrite <= write;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready)
		begin
			@(posedge clk);
			@(negedge clk);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_access(input ctrl_map_pkg::sel_e sel, input int ofs, input logic write,
		input logic [DW-1:0] wdata);
		logic [AW-1:0] addr;
		logic [DW-1:0] rdata;
		logic err;
		logic [DW-1:0] exp_data;
		logic exp_err;
		addr = reg_addr(sel, ofs);
		expected_read(addr, write, exp_data, exp_err);
		apb_transfer(addr, write, wdata, rdata, err);
		compare_err("pslverr", err, exp_err);
		if (!write && !exp_err)
			compare_data("prdata", rdata, exp_data);
		if (write && !exp_err)
		begin
			if (sel == ctrl_map_pkg::SEL_PLATFORM && ofs == 3)
				scratch_m = wdata;
			if (sel == ctrl_map_pkg::SEL_PLATFORM && ofs == 2)
				app_m = wdata[0];
			if (sel == ctrl_map_pkg::SEL_EXTERNAL)
				ext_m[ofs] = wdata;
		end
	endtask

	// Request a mask, then follow the release one domain per step
	task automatic check_request(input logic [NUM_RESET-1:0] mask);
		logic [NUM_RESET-1:0] exp;
		check_access(ctrl_map_pkg::SEL_RESET, 1, 1'b1, DW'(mask));
		exp = rst_m & ~mask;
		@(negedge clk);
		compare_rst(rst_n_seq, exp);
		for (int j = 1; j <= NUM_RESET * STEP_CYCLES; j++)
		begin
			@(posedge clk);
			@(negedge clk);
			if (j % STEP_CYCLES == 0)
			begin
				for (int k = 0; k < NUM_RESET; k++)
				begin
					if (!exp[k])
					begin
						exp[k] = 1'b1;
						break;
					end
				end
			end
			compare_rst(rst_n_seq, exp);
		end
		rst_m = exp;
		check_access(ctrl_map_pkg::SEL_RESET, 0, 1'b0, '0);
	endtask

	// **************************************************
	// Scenarios
	// **************************************************

	initial
	begin
		void'($urandom(78624));
		rst_n <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		paddr <= '0;
		pwrite <= 1'b0;
		pwdata <= '0;
		ext_prdata <= '0;
		ext_pready <= 1'b0;
		ext_pslverr <= 1'b0;
		wait_left <= 0;
		boot_mode = ctrl_reg_pkg::BW_BOOT_MODE'($urandom_range(0, 3));
		initialized = NUM_CORE'($urandom_range(0, (1 << NUM_CORE) - 1));
		for (int k = 0; k < NUM_CORE; k++)
			pc_list[k*DW +: DW] = $urandom;
		for (int i = 0; i < 16; i++)
		begin
			ext_mem[i] <= fill_word(i);
			ext_m[i] = fill_word(i);
		end
		scratch_m = '0;
		app_m = 1'b0;

		repeat (2) @(posedge clk);
		@(negedge clk);
		compare_rst(rst_n_seq, '0);
		compare_err("o_app_finished", app_finished, 1'b0);
		@(posedge clk);
		rst_n <= 1'b1;

		// Bit k comes up at edge (k+1)*STEP_CYCLES after release
		for (int e = 0; e <= (NUM_RESET + 1) * STEP_CYCLES; e++)
		begin
			@(posedge clk);
			@(negedge clk);
			for (int k = 0; k < NUM_RESET; k++)
				rst_m[k] = (e >= (k + 1) * STEP_CYCLES);
			compare_rst(rst_n_seq, rst_m);
		end
		check_access(ctrl_map_pkg::SEL_RESET, 0, 1'b0, '0);

		// Platform registers
		for (int ofs = 0; ofs < 4; ofs++)
			check_access(ctrl_map_pkg::SEL_PLATFORM, ofs, 1'b0, '0);
		for (int k = 0; k < NUM_CORE; k++)
			check_access(ctrl_map_pkg::SEL_PLATFORM, 16 + k, 1'b0, '0);
		check_access(ctrl_map_pkg::SEL_PLATFORM, 3, 1'b1, $urandom);
		check_access(ctrl_map_pkg::SEL_PLATFORM, 3, 1'b0, '0);
		check_access(ctrl_map_pkg::SEL_PLATFORM, 2, 1'b1, 32'h1);
		@(negedge clk);
		compare_err("o_app_finished", app_finished, 1'b1);
		check_access(ctrl_map_pkg::SEL_PLATFORM, 2, 1'b0, '0);
		check_access(ctrl_map_pkg::SEL_PLATFORM, 2, 1'b1, 32'h0);
		@(negedge clk);
		compare_err("o_app_finished", app_finished, 1'b0);

		// Design information
		for (int ofs = 0; ofs < 4; ofs++)
			check_access(ctrl_map_pkg::SEL_INFO, ofs, 1'b0, '0);

		// Error responses
		check_access(ctrl_map_pkg::SEL_RESET, 0, 1'b1, 32'h0);
		check_access(ctrl_map_pkg::SEL_RESET, 1, 1'b0, '0);
		check_access(ctrl_map_pkg::SEL_RESET, 7, 1'b0, '0);
		check_access(ctrl_map_pkg::SEL_PLATFORM, 0, 1'b1, 32'h3);
		check_access(ctrl_map_pkg::SEL_PLATFORM, 16, 1'b1, 32'h5);
		check_access(ctrl_map_pkg::SEL_PLATFORM, 9, 1'b0, '0);
		check_access(ctrl_map_pkg::SEL_INFO, 1, 1'b1, 32'h1);
		check_access(ctrl_map_pkg::SEL_INFO, 12, 1'b0, '0);

		// External window
		for (int n = 0; n < NUM_EXT_OPS; n++)
			check_access(ctrl_map_pkg::SEL_EXTERNAL, $urandom_range(0, 15),
				1'($urandom_range(0, 1)), $urandom);
		check_access(ctrl_map_pkg::SEL_EXTERNAL, 16, 1'b0, '0);
		check_access(ctrl_map_pkg::SEL_EXTERNAL, 200, 1'b1, 32'hDEAD_0001);

		for (int r = 0; r < NUM_REQ_ROUNDS; r++)
			check_request(NUM_RESET'($urandom_range(1, (1 << NUM_RESET) - 1)));

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+test
hdl/ctrl_map_pkg.sv
hdl/ctrl_reg_pkg.sv
hdl/apb_splitter.sv
hdl/reset_sequencer.sv
hdl/platform_regs.sv
hdl/design_info_rom.sv
hdl/platform_controller.sv
test/tb_platform_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the platform controller testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module tb_platform_controller \
	--Mdir obj_dir -o sim_platform_controller &&
./obj_dir/sim_platform_controller | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "Result: pass" ||
{ echo "Result: fail"; exit 1; }
